// ==== src/bal_macros.svh ====
`ifndef BAL_MACROS_SVH
`define BAL_MACROS_SVH

// Pitch and pitch-rate sample width.
`define BAL_PTCH_W 16

// PID correction and motor command width.
`define BAL_CNTRL_W 12

// Signed steering value width.
`define BAL_STEER_W 12

// Proportional gain.
`define BAL_P_COEFF 9

// PWM magnitude and period counter width.
`define BAL_PWM_W 11

`endif

// ==== src/bal_pkg.sv ====
`include "bal_macros.svh"

package bal_pkg;

    // Raw sensor sample, pitch or pitch rate.
    typedef logic signed [`BAL_PTCH_W-1:0] ptch_t;

    // Saturated PID output.
    typedef logic signed [`BAL_CNTRL_W-1:0] cntrl_t;

    // Signed wheel command, negative is reverse.
    typedef logic signed [`BAL_CNTRL_W-1:0] mtr_cmd_t;

endpackage

// ==== src/axil_pkg.sv ====
package axil_pkg;

    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10
    } axil_resp_t;

    // Byte addresses of the register file.
    typedef enum logic [4:0] {
        REG_CTRL  = 5'h00,
        REG_STEER = 5'h04,
        REG_PID   = 5'h08,  // Read only.
        REG_SS    = 5'h0C,  // Read only.
        REG_MTR   = 5'h10   // Read only.
    } reg_addr_t;

endpackage

// ==== src/pid_ctrl.sv ====
`include "bal_macros.svh"

module pid_ctrl
    import bal_pkg::*;
#(
    parameter int SS_LSB = 19
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       vld,
    input  logic       pwr_up,
    input  logic       rider_off,
    input  ptch_t      ptch,
    input  ptch_t      ptch_rt,
    output cntrl_t     pid_cntrl,
    output logic [7:0] ss_tmr
);
    localparam int TMR_W  = SS_LSB + 8;
    localparam int ERR_W  = 10;
    localparam int INTG_W = 18;
    localparam int SUM_W  = 16;
    localparam logic signed [SUM_W-1:0] CNTRL_MAX = 2 ** (`BAL_CNTRL_W - 1) - 1;
    localparam logic signed [SUM_W-1:0] CNTRL_MIN = -(2 ** (`BAL_CNTRL_W - 1));

    logic signed [ERR_W-1:0]  err_sat;
    logic signed [INTG_W-1:0] err_ext;
    logic signed [INTG_W-1:0] integ;
    logic signed [INTG_W-1:0] integ_nxt;
    logic                     integ_ovf;
    logic signed [SUM_W-1:0]  p_term;
    logic signed [SUM_W-1:0]  i_term;
    logic signed [SUM_W-1:0]  d_term;
    logic signed [SUM_W-1:0]  pid_sum;
    logic [TMR_W-1:0]         long_tmr;

    // Clamp pitch error to 10 signed bits.
    always_comb begin
        if (ptch[`BAL_PTCH_W-1] && !(&ptch[`BAL_PTCH_W-2:ERR_W-1]))
            err_sat = {1'b1, {(ERR_W-1){1'b0}}};
        else if (!ptch[`BAL_PTCH_W-1] && (|ptch[`BAL_PTCH_W-2:ERR_W-1]))
            err_sat = {1'b0, {(ERR_W-1){1'b1}}};
        else
            err_sat = ptch[ERR_W-1:0];
    end

    assign err_ext   = INTG_W'(err_sat);
    assign integ_nxt = integ + err_ext;
    // Same-sign operands whose sum flips sign.
    assign integ_ovf = (integ[INTG_W-1] == err_ext[INTG_W-1]) &&
                       (integ_nxt[INTG_W-1] != integ[INTG_W-1]);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            integ <= '0;
        else if (!pwr_up || rider_off)
            integ <= '0;
        else if (vld && !integ_ovf)
            integ <= integ_nxt;
    end

    assign p_term  = SUM_W'(err_sat) * SUM_W'(`BAL_P_COEFF);
    assign i_term  = SUM_W'(integ >>> 6);
    assign d_term  = SUM_W'(ptch_rt >>> 6);
    assign pid_sum = p_term + i_term - d_term;

    always_comb begin
        if (pid_sum > CNTRL_MAX)
            pid_cntrl = cntrl_t'(CNTRL_MAX);
        else if (pid_sum < CNTRL_MIN)
            pid_cntrl = cntrl_t'(CNTRL_MIN);
        else
            pid_cntrl = pid_sum[`BAL_CNTRL_W-1:0];
    end

    // Soft-start ramp, one-shot up to all ones.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            long_tmr <= '0;
        else if (!pwr_up)
            long_tmr <= '0;
        else if (!(&long_tmr[TMR_W-1:SS_LSB]))
            long_tmr <= long_tmr + TMR_W'(1);
    end

    assign ss_tmr = long_tmr[TMR_W-1:SS_LSB];

endmodule

// ==== src/steer_mix.sv ====
`include "bal_macros.svh"

module steer_mix
    import bal_pkg::*;
(
    input  logic                           clk,
    input  logic                           rst_n,
    input  cntrl_t                         pid_cntrl,
    input  logic [7:0]                     ss_tmr,
    input  logic                           steer_en,
    input  logic signed [`BAL_STEER_W-1:0] steer,
    output mtr_cmd_t                       lft_cmd,
    output mtr_cmd_t                       rght_cmd
);
    localparam int PROD_W = `BAL_CNTRL_W + 9;
    localparam int MIX_W  = `BAL_CNTRL_W + 2;
    localparam logic signed [MIX_W-1:0] CMD_MAX = 2 ** (`BAL_CNTRL_W - 1) - 1;
    localparam logic signed [MIX_W-1:0] CMD_MIN = -(2 ** (`BAL_CNTRL_W - 1));

    logic signed [PROD_W-1:0] prod;
    logic signed [MIX_W-1:0]  scaled;
    logic signed [MIX_W-1:0]  steer_x;
    logic signed [MIX_W-1:0]  lft_sum;
    logic signed [MIX_W-1:0]  rght_sum;

    function automatic mtr_cmd_t sat_cmd(input logic signed [MIX_W-1:0] v);
        mtr_cmd_t r;
        if (v > CMD_MAX)
            r = mtr_cmd_t'(CMD_MAX);
        else if (v < CMD_MIN)
            r = mtr_cmd_t'(CMD_MIN);
        else
            r = v[`BAL_CNTRL_W-1:0];
        return r;
    endfunction

    // Ramp factor is ss_tmr/256, kept positive.
    assign prod   = PROD_W'(pid_cntrl) * PROD_W'($signed({1'b0, ss_tmr}));
    assign scaled = MIX_W'(prod >>> 8);

    assign steer_x  = steer_en ? MIX_W'(steer) : '0;
    assign lft_sum  = scaled + steer_x;
    assign rght_sum = scaled - steer_x;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lft_cmd  <= '0;
            rght_cmd <= '0;
        end else begin
            lft_cmd  <= sat_cmd(lft_sum);
            rght_cmd <= sat_cmd(rght_sum);
        end
    end

endmodule

// ==== src/mtr_pwm.sv ====
`include "bal_macros.svh"

module mtr_pwm
    import bal_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  mtr_cmd_t cmd,
    output logic     pwm,
    output logic     rev
);
    localparam mtr_cmd_t NEG_FULL = {1'b1, {(`BAL_CNTRL_W-1){1'b0}}};

    logic [`BAL_CNTRL_W-1:0] neg_cmd;
    logic [`BAL_PWM_W-1:0]   mag;
    logic [`BAL_PWM_W-1:0]   mag_q;
    logic [`BAL_PWM_W-1:0]   cnt;

    assign neg_cmd = -cmd;

    always_comb begin
        if (!cmd[`BAL_CNTRL_W-1])
            mag = cmd[`BAL_PWM_W-1:0];
        else if (cmd == NEG_FULL)
            mag = '1;                               // -2048 has no 11-bit magnitude.
        else
            mag = neg_cmd[`BAL_PWM_W-1:0];
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt   <= '0;
            mag_q <= '0;
            rev   <= 1'b0;
        end else begin
            cnt <= cnt + `BAL_PWM_W'(1);
            if (&cnt) begin                         // Reload at wrap.
                mag_q <= mag;
                rev   <= cmd[`BAL_CNTRL_W-1];
            end
        end
    end

    assign pwm = (cnt < mag_q);

endmodule

// ==== src/bal_regs.sv ====
`include "bal_macros.svh"

module bal_regs
    import axil_pkg::*;
    import bal_pkg::*;
(
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic [31:0]                    awaddr,
    input  logic                           awvalid,
    output logic                           awready,
    input  logic [31:0]                    wdata,
    input  logic [3:0]                     wstrb,
    input  logic                           wvalid,
    output logic                           wready,
    output logic [1:0]                     bresp,
    output logic                           bvalid,
    input  logic                           bready,
    input  logic [31:0]                    araddr,
    input  logic                           arvalid,
    output logic                           arready,
    output logic [31:0]                    rdata,
    output logic [1:0]                     rresp,
    output logic                           rvalid,
    input  logic                           rready,
    output logic                           pwr_up,
    output logic                           steer_en,
    output logic signed [`BAL_STEER_W-1:0] steer,
    input  cntrl_t                         pid_cntrl,
    input  logic [7:0]                     ss_tmr,
    input  mtr_cmd_t                       lft_cmd,
    input  mtr_cmd_t                       rght_cmd
);
    logic        wr_go;
    logic        wr_ctrl;
    logic        wr_steer;
    logic        rd_hit;
    logic [31:0] rd_word;

    assign wr_go    = awvalid && awready && wvalid && wready;
    assign wr_ctrl  = (awaddr == 32'(REG_CTRL));
    assign wr_steer = (awaddr == 32'(REG_STEER));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            awready  <= 1'b0;
            wready   <= 1'b0;
            bvalid   <= 1'b0;
            bresp    <= OKAY;
            pwr_up   <= 1'b0;
            steer_en <= 1'b0;
            steer    <= '0;
        end else begin
            awready <= 1'b0;
            wready  <= 1'b0;
            if (wr_go) begin
                bvalid <= 1'b1;
                bresp  <= (wr_ctrl || wr_steer) ? OKAY : SLVERR;
                if (wr_ctrl && wstrb[0]) begin
                    pwr_up   <= wdata[0];
                    steer_en <= wdata[1];
                end
                if (wr_steer && wstrb[0])
                    steer[7:0] <= wdata[7:0];
                if (wr_steer && wstrb[1])
                    steer[`BAL_STEER_W-1:8] <= wdata[`BAL_STEER_W-1:8];
            end else if (bvalid && bready) begin
                bvalid <= 1'b0;
            end else if (awvalid && wvalid && !bvalid && !awready) begin
                awready <= 1'b1;                    // One-cycle accept pulse.
                wready  <= 1'b1;
            end
        end
    end

    always_comb begin
        rd_hit  = 1'b1;
        rd_word = '0;
        case (araddr)
            32'(REG_CTRL):  rd_word = {30'b0, steer_en, pwr_up};
            32'(REG_STEER): rd_word[`BAL_STEER_W-1:0] = steer;
            32'(REG_PID):   rd_word = 32'(pid_cntrl);
            32'(REG_SS):    rd_word = 32'(ss_tmr);
            32'(REG_MTR):   rd_word = {16'(rght_cmd), 16'(lft_cmd)};
            default:        rd_hit = 1'b0;
        endcase
    end

    // Status is sampled at address accept.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
            rdata   <= '0;
            rresp   <= OKAY;
        end else if (arvalid && arready) begin
            arready <= 1'b0;
            rvalid  <= 1'b1;
            rdata   <= rd_word;
            rresp   <= rd_hit ? OKAY : SLVERR;
        end else if (rvalid && rready) begin
            rvalid  <= 1'b0;
            arready <= 1'b1;
        end else if (!rvalid) begin
            arready <= 1'b1;
        end
    end

endmodule

// ==== src/bal_top.sv ====
`include "bal_macros.svh"

module bal_top
    import bal_pkg::*;
#(
    parameter int SS_LSB = 19
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [31:0] awaddr,
    input  logic        awvalid,
    output logic        awready,
    input  logic [31:0] wdata,
    input  logic [3:0]  wstrb,
    input  logic        wvalid,
    output logic        wready,
    output logic [1:0]  bresp,
    output logic        bvalid,
    input  logic        bready,
    input  logic [31:0] araddr,
    input  logic        arvalid,
    output logic        arready,
    output logic [31:0] rdata,
    output logic [1:0]  rresp,
    output logic        rvalid,
    input  logic        rready,
    input  logic        vld,
    input  ptch_t       ptch,
    input  ptch_t       ptch_rt,
    input  logic        rider_off,
    output logic        lft_pwm,
    output logic        lft_rev,
    output logic        rght_pwm,
    output logic        rght_rev
);
    logic                           pwr_up;
    logic                           steer_en;
    logic signed [`BAL_STEER_W-1:0] steer;
    cntrl_t                         pid_cntrl;
    logic [7:0]                     ss_tmr;
    mtr_cmd_t                       lft_cmd;
    mtr_cmd_t                       rght_cmd;

    bal_regs i_regs (.*);   // Port names match the top and the wires.

    pid_ctrl #(.SS_LSB(SS_LSB)) i_pid (.*);

    steer_mix i_mix (.*);

    mtr_pwm i_lft_pwm (.clk(clk), .rst_n(rst_n), .cmd(lft_cmd), .pwm(lft_pwm), .rev(lft_rev));

    mtr_pwm i_rght_pwm (.clk(clk), .rst_n(rst_n), .cmd(rght_cmd), .pwm(rght_pwm), .rev(rght_rev));

endmodule

// ==== verif/tb_clk_gen.sv ====
module tb_clk_gen (
    output logic clk,
    output logic rst_n
);
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Reset held for eight clock cycles, released mid-cycle.
    initial begin
        rst_n = 1'b0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

// ==== verif/tb_bal_top.sv ====
`include "bal_macros.svh"

module tb_bal_top
    import bal_pkg::*;
    import axil_pkg::*;
();
    localparam int MAX_CYCLES = 20000;

    logic        clk;
    logic        rst_n;
    logic [31:0] awaddr;
    logic        awvalid;
    logic        awready;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        wvalid;
    logic        wready;
    logic [1:0]  bresp;
    logic        bvalid;
    logic        bready;
    logic [31:0] araddr;
    logic        arvalid;
    logic        arready;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic        rvalid;
    logic        rready;
    logic        vld;
    ptch_t       ptch;
    ptch_t       ptch_rt;
    logic        rider_off;
    logic        lft_pwm;
    logic        lft_rev;
    logic        rght_pwm;
    logic        rght_rev;
    int          errors;
    int          tests;
    int          cycles = 0;
    integer      seed;

    tb_clk_gen i_clk (.clk(clk), .rst_n(rst_n));

    bal_top #(.SS_LSB(2)) i_dut (.*);   // Timer tops out after about 1024 cycles.

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == MAX_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles.", MAX_CYCLES);
            $display("Done: errors found");
            $finish;
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n) bvalid && !bready |=> bvalid)
        else log_fail("bvalid dropped before bready");
    assert property (@(posedge clk) disable iff (!rst_n)
                     rvalid && !rready |=> rvalid && $stable(rdata))
        else log_fail("rvalid or rdata changed before rready");
    assert property (@(posedge clk) disable iff (!rst_n) awready == wready)
        else log_fail("awready and wready out of step");
    assert property (@(posedge clk) disable iff (!rst_n)
                     arvalid && arready |=> rvalid && !arready)
        else log_fail("read accept did not raise rvalid or drop arready");

    function automatic int sat_to(input int v, input int bits);
        int lim;
        lim = 1 << (bits - 1);
        if (v > lim - 1)
            return lim - 1;
        if (v < -lim)
            return -lim;
        return v;
    endfunction

    // Error clamped to 10 bits, integral /64, rate >>> 6.
    function automatic int pid_model(input int p, input int rt, input int integ);
        return sat_to(sat_to(p, 10) * `BAL_P_COEFF + (integ >>> 6) - (rt >>> 6), `BAL_CNTRL_W);
    endfunction

    function automatic int integ_step(input int integ, input int p);
        int n;
        n = integ + sat_to(p, 10);
        return (n != sat_to(n, 18)) ? integ : n;    // Holds on overflow.
    endfunction

    function automatic int mix_scale(input int c, input int ss);
        return (c * ss) >>> 8;
    endfunction

    function automatic int pwm_mag(input int cmd);
        return (cmd < 0) ? sat_to(-cmd, 12) : cmd;
    endfunction

    task automatic log_fail(input string msg);
        errors++;
        $display("FAIL %0t: %s", $time, msg);
    endtask

    task automatic end_test(input string name);
        tests++;
        $display("Test %0d %s finished, %0d errors so far", tests, name, errors);
    endtask

    task automatic axi_write(input logic [31:0] addr, input logic [31:0] data,
                             input logic [3:0] strb, input int bstall,
                             output logic [1:0] resp);
        @(negedge clk);
        awaddr  = addr;
        wdata   = data;
        wstrb   = strb;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        bready  = (bstall == 0);
        @(negedge clk);
        while (!awready) @(negedge clk);
        @(negedge clk);                             // Accepted on the edge just passed.
        awvalid = 1'b0;
        wvalid  = 1'b0;
        while (!bvalid) @(negedge clk);
        repeat (bstall) @(negedge clk);
        resp   = bresp;
        bready = 1'b1;
    endtask

    task automatic axi_read(input logic [31:0] addr, input int rstall,
                            output logic [31:0] data, output logic [1:0] resp);
        @(negedge clk);
        araddr  = addr;
        arvalid = 1'b1;
        rready  = (rstall == 0);
        while (!arready) @(negedge clk);
        @(negedge clk);                             // Accepted on the edge just passed.
        arvalid = 1'b0;
        while (!rvalid) @(negedge clk);
        repeat (rstall) @(negedge clk);
        data   = rdata;
        resp   = rresp;
        rready = 1'b1;
    endtask

    task automatic expect_write(input logic [31:0] addr, input logic [31:0] data,
                                input logic [3:0] strb, input logic [1:0] exp_resp);
        logic [1:0] r;
        axi_write(addr, data, strb, 0, r);
        assert (r == exp_resp)
            else log_fail($sformatf("write 0x%0h resp %0d, expected %0d", addr, r, exp_resp));
    endtask

    task automatic expect_read(input logic [31:0] addr, input logic [31:0] exp,
                               input logic [1:0] exp_resp);
        logic [31:0] d;
        logic [1:0]  r;
        axi_read(addr, 0, d, r);
        assert (d == exp && r == exp_resp)
            else log_fail($sformatf("read 0x%0h gave 0x%0h resp %0d, expected 0x%0h resp %0d",
                                    addr, d, r, exp, exp_resp));
    endtask

    task automatic read_mtr(output int lft, output int rght);
        logic [31:0] d;
        logic [1:0]  r;
        axi_read(32'(REG_MTR), 0, d, r);
        lft  = $signed(d[11:0]);
        rght = $signed(d[27:16]);
    endtask

    initial begin
        logic [31:0] d;
        logic [1:0]  resp;
        int          integ;
        int          c;
        int          ss_a;
        int          ss_b;
        int          prev;
        int          lft;
        int          rght;
        int          lft_exp;
        int          rght_exp;
        int          lft_hi;
        int          rght_hi;

        errors    = 0;
        tests     = 0;
        seed      = 32'h859e_0470;
        awaddr    = '0;
        awvalid   = 1'b0;
        wdata     = '0;
        wstrb     = '0;
        wvalid    = 1'b0;
        bready    = 1'b1;
        araddr    = '0;
        arvalid   = 1'b0;
        rready    = 1'b1;
        vld       = 1'b0;
        ptch      = '0;
        ptch_rt   = '0;
        rider_off = 1'b0;
        wait (rst_n);

        assert (!bvalid && !rvalid) else log_fail("bvalid or rvalid high after reset");
        axi_write(32'(REG_CTRL), 32'h2, 4'hF, 3, resp);
        assert (resp == OKAY) else log_fail("CTRL write with held-off bready not OKAY");
        axi_read(32'(REG_CTRL), 2, d, resp);
        assert (d == 32'h2 && resp == OKAY) else log_fail("CTRL read with held-off rready");
        expect_write(32'(REG_CTRL), 32'h3, 4'h2, OKAY); // Byte 0 not strobed.
        expect_read(32'(REG_CTRL), 32'h2, OKAY);
        expect_write(32'(REG_STEER), 32'h123, 4'hF, OKAY);
        expect_read(32'(REG_STEER), 32'h123, OKAY);
        expect_write(32'(REG_STEER), 32'hABC, 4'h2, OKAY);
        expect_read(32'(REG_STEER), 32'hA23, OKAY);
        expect_write(32'(REG_PID), 32'h1, 4'hF, SLVERR);
        expect_write(32'h20, 32'h1, 4'hF, SLVERR);
        expect_read(32'h20, 32'h0, SLVERR);
        expect_write(32'(REG_CTRL), 32'h0, 4'hF, OKAY);
        expect_write(32'(REG_STEER), 32'h0, 4'hF, OKAY);
        end_test("register access");

        expect_read(32'(REG_SS), 32'h0, OKAY);
        for (int i = 0; i < 22; i++) begin
            ptch    = ptch_t'($random(seed)) >>> (i % 8);
            ptch_rt = ptch_t'($random(seed));
            if (i == 20)
                ptch = 16'h7FFF;                    // Upper limit.
            if (i == 21)
                ptch = 16'h8000;                    // Lower limit.
            expect_read(32'(REG_PID), 32'(pid_model(ptch, ptch_rt, 0)), OKAY);
        end
        end_test("proportional and derivative path");

        ptch    = 16'sd100;
        ptch_rt = '0;
        expect_write(32'(REG_CTRL), 32'h1, 4'hF, OKAY);
        integ = 0;
        repeat (10) begin
            @(negedge clk);
            vld = 1'b1;
            @(negedge clk);
            vld   = 1'b0;
            integ = integ_step(integ, 100);
        end
        expect_read(32'(REG_PID), 32'(pid_model(100, 0, integ)), OKAY);
        rider_off = 1'b1;
        @(negedge clk);
        expect_read(32'(REG_PID), 32'(pid_model(100, 0, 0)), OKAY);
        rider_off = 1'b0;
        integ     = 0;
        // Full-scale error runs the 18-bit integrator into its limit.
        ptch = 16'sd511;
        vld  = 1'b1;
        repeat (300) begin
            @(negedge clk);
            integ = integ_step(integ, 511);
        end
        vld  = 1'b0;
        ptch = '0;
        expect_read(32'(REG_PID), 32'(pid_model(0, 0, integ)), OKAY);
        end_test("integrator and clears");

        expect_write(32'(REG_CTRL), 32'h0, 4'hF, OKAY);
        ptch = 16'sd40;
        c    = pid_model(40, 0, 0);
        expect_write(32'(REG_CTRL), 32'h1, 4'hF, OKAY);
        prev = 0;
        ss_b = 0;
        while (ss_b != 255) begin
            axi_read(32'(REG_SS), 0, d, resp);
            ss_a = int'(d);
            read_mtr(lft, rght);
            axi_read(32'(REG_SS), 0, d, resp);
            ss_b = int'(d);
            assert (ss_a >= prev && ss_b >= ss_a)
                else log_fail($sformatf("SS went %0d, %0d, %0d", prev, ss_a, ss_b));
            assert (lft >= mix_scale(c, ss_a) && lft <= mix_scale(c, ss_b) && rght == lft)
                else log_fail($sformatf("MTR %0d/%0d outside ramp %0d..%0d",
                                        lft, rght, mix_scale(c, ss_a), mix_scale(c, ss_b)));
            prev = ss_b;
        end
        repeat (50) @(negedge clk);
        expect_read(32'(REG_SS), 32'd255, OKAY);
        read_mtr(lft, rght);
        assert (lft == mix_scale(c, 255) && rght == lft)
            else log_fail($sformatf("MTR %0d/%0d at full ramp", lft, rght));
        end_test("soft start");

        expect_write(32'(REG_STEER), 32'h8F8, 4'hF, OKAY);   // Steer of -1800.
        expect_write(32'(REG_CTRL), 32'h3, 4'hF, OKAY);
        lft_exp  = sat_to(mix_scale(c, 255) - 1800, 12);
        rght_exp = sat_to(mix_scale(c, 255) + 1800, 12);
        read_mtr(lft, rght);
        assert (lft == lft_exp && rght == rght_exp)
            else log_fail($sformatf("MTR %0d/%0d, expected %0d/%0d",
                                    lft, rght, lft_exp, rght_exp));
        // First period lets both generators reload. The second is counted.
        repeat (2048) @(negedge clk);
        lft_hi  = 0;
        rght_hi = 0;
        repeat (2048) begin
            @(negedge clk);
            lft_hi  += int'(lft_pwm);
            rght_hi += int'(rght_pwm);
        end
        assert (lft_hi == pwm_mag(lft_exp) && rght_hi == pwm_mag(rght_exp))
            else log_fail($sformatf("PWM high counts %0d/%0d", lft_hi, rght_hi));
        assert (lft_rev == (lft_exp < 0) && rght_rev == (rght_exp < 0))
            else log_fail("rev pins do not match command signs");
        end_test("steering and motor outputs");

        $display("Tests run: %0d, errors: %0d", tests, errors);
        if (errors == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

// ==== project.f ====
+incdir+src
src/bal_pkg.sv
src/axil_pkg.sv
src/pid_ctrl.sv
src/steer_mix.sv
src/mtr_pwm.sv
src/bal_regs.sv
src/bal_top.sv
verif/tb_clk_gen.sv
verif/tb_bal_top.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module tb_bal_top -f project.f

# Output goes to the terminal and is searched for the pass line.
./obj_dir/Vtb_bal_top | tee /dev/stderr | grep -x "Done: no errors" > /dev/null

echo "Simulation passed."
